// File: hw/router_stats_macros.svh
/* Router statistics constants */

`ifndef ROUTER_STATS_MACROS_SVH
`define ROUTER_STATS_MACROS_SVH

// Port counts
`define ROUTER_NUM_ING_PORTS 11
`define ROUTER_NUM_EGR_PORTS 11

// Counter and bus widths
`define ROUTER_CNTR_WIDTH 32
`define ROUTER_AVMM_ADDR_WIDTH 15
`define ROUTER_AVMM_DATA_WIDTH 32

// Identity word fields
`define ROUTER_MODULE_ID 10
`define ROUTER_MODULE_VERSION 16'h0100

// Datapath parameters reported through PARAMS0 and PARAMS1
`define ROUTER_MTU_BYTES 2000
`define ROUTER_DATA_BYTES 64
`define ROUTER_CLK_PERIOD_PS 8000

// Snapshot words per port
`define ROUTER_ING_CNTRS_PER_PORT 5
`define ROUTER_EGR_CNTRS_PER_PORT 4

`endif

// File: hw/router_stats_pkg.sv
/* Router statistics types */

`include "router_stats_macros.svh"

package router_stats_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY        = 2'b00,
        RESP_SLAVE_ERROR = 2'b10
    } avmm_resp_e;

    // Avalon-MM request from the bus master
    typedef struct packed {
        logic [`ROUTER_AVMM_ADDR_WIDTH-1:0]   address;
        logic                                 read;
        logic                                 write;
        logic [`ROUTER_AVMM_DATA_WIDTH-1:0]   writedata;
        logic [`ROUTER_AVMM_DATA_WIDTH/8-1:0] byteenable;
    } avmm_req_t;

    typedef struct packed {
        logic [`ROUTER_AVMM_DATA_WIDTH-1:0] readdata;
        logic                               readdatavalid;
        avmm_resp_e                         response;
        logic                               writeresponsevalid;
    } avmm_rsp_t;

    // Traffic-profile monitor counts, word 0 first
    typedef struct packed {
        logic [`ROUTER_CNTR_WIDTH-1:0] pkt_cnt;
        logic [`ROUTER_CNTR_WIDTH-1:0] byte_cnt;
        logic [`ROUTER_CNTR_WIDTH-1:0] err_cnt;
    } prof_cnt_t;

    typedef struct packed {
        prof_cnt_t                     prof;
        logic [`ROUTER_CNTR_WIDTH-1:0] async_fifo_ovf_cnt;
        logic [`ROUTER_CNTR_WIDTH-1:0] buf_ovf_cnt;
    } ing_cnt_set_t;

    typedef struct packed {
        prof_cnt_t                     prof;
        logic [`ROUTER_CNTR_WIDTH-1:0] buf_full_drop_cnt;
    } egr_cnt_set_t;

    // Read-select register layout
    typedef struct packed {
        logic [7:0] port;
        logic [7:0] cntr;
    } cntr_sel_t;

    typedef enum logic [`ROUTER_AVMM_ADDR_WIDTH-3:0] {
        VERSION_ID, PARAMS0, PARAMS1,
        ING_PORT_ENABLE_CON, EGR_PORT_ENABLE_CON,
        ING_PORT_ENABLE_STAT, EGR_PORT_ENABLE_STAT,
        ING_CNTRS_SAMPLE_CON, ING_CNTRS_READ_SEL, ING_CNTRS_READ_DATA,
        EGR_CNTRS_SAMPLE_CON, EGR_CNTRS_READ_SEL, EGR_CNTRS_READ_DATA,
        ING_POLICER_ENABLE,
        REG_COUNT
    } reg_addr_e;

endpackage

// File: hw/port_stats_bank.sv
/* Per-direction port statistics bank */

`timescale 1ns/10ps
`include "router_stats_macros.svh"

module port_stats_bank
    import router_stats_pkg::*;
#(
    parameter int NUM_PORTS      = `ROUTER_NUM_ING_PORTS,
    parameter int NUM_EVENTS     = 2,
    parameter int CNTRS_PER_PORT = `ROUTER_ING_CNTRS_PER_PORT,
    parameter type cnt_set_t     = ing_cnt_set_t
) (
    input  logic                                 avmm_clk_ifc,
    input  logic                                 peripheral_sresetn_core,
    input  prof_cnt_t [NUM_PORTS-1:0]            prof_cnts,
    input  logic [NUM_PORTS-1:0][NUM_EVENTS-1:0] drop_events,
    input  logic [NUM_PORTS-1:0]                 sample_con,
    input  cntr_sel_t                            read_sel,
    output logic [`ROUTER_CNTR_WIDTH-1:0]        read_data
);

    localparam int W          = `ROUTER_CNTR_WIDTH;
    localparam int PORT_IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [NUM_PORTS-1:0]                 sample_d;
    logic [NUM_PORTS-1:0]                 sample_rise;
    logic [NUM_PORTS-1:0][NUM_EVENTS-1:0] drop_d;
    logic [NUM_PORTS-1:0][NUM_EVENTS-1:0] drop_rise;

    logic [W-1:0]            evt_cnt  [NUM_PORTS][NUM_EVENTS];
    logic [NUM_EVENTS*W-1:0] evt_flat [NUM_PORTS];
    cnt_set_t                snap     [NUM_PORTS];

    logic                      sel_valid;
    logic [CNTRS_PER_PORT*W-1:0] sel_flat;
    int                        word_off;
    logic [W-1:0]              sel_word;

    assign sample_rise = sample_con & ~sample_d;
    assign drop_rise   = drop_events & ~drop_d;

    // Highest event index lands right after the profile words
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int e = 0; e < NUM_EVENTS; e++) begin
                evt_flat[p][e*W +: W] = evt_cnt[p][e];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Drop counting and snapshot
    ////////////////////////////////////////////////////////////

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_d <= '0;
            drop_d   <= '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                snap[p] <= '0;
                for (int e = 0; e < NUM_EVENTS; e++) begin
                    evt_cnt[p][e] <= '0;
                end
            end
        end else begin
            sample_d <= sample_con;
            drop_d   <= drop_events;
            for (int p = 0; p < NUM_PORTS; p++) begin
                for (int e = 0; e < NUM_EVENTS; e++) begin
                    // Clear on sample, but keep an edge landing in the same cycle
                    if (sample_rise[p]) begin
                        evt_cnt[p][e] <= W'(drop_rise[p][e]);
                    end else if (drop_rise[p][e]) begin
                        evt_cnt[p][e] <= evt_cnt[p][e] + W'(1);
                    end
                end
                if (sample_rise[p]) begin
                    snap[p] <= cnt_set_t'({prof_cnts[p], evt_flat[p]});
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Selected word
    ////////////////////////////////////////////////////////////

    assign sel_valid = (int'(read_sel.port) < NUM_PORTS) &&
                       (int'(read_sel.cntr) < CNTRS_PER_PORT);

    // Word 0 sits at the top of the packed snapshot
    always_comb begin
        sel_flat = '0;
        word_off = 0;
        sel_word = '0;
        if (sel_valid) begin
            sel_flat = snap[read_sel.port[PORT_IDX_W-1:0]];
            word_off = (CNTRS_PER_PORT - 1 - int'(read_sel.cntr)) * W;
            sel_word = sel_flat[word_off +: W];
        end
    end

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            read_data <= '0;
        end else begin
            read_data <= sel_word;
        end
    end

endmodule

// File: hw/router_regs_avmm.sv
/* Router control and statistics registers */

`timescale 1ns/10ps
`include "router_stats_macros.svh"

module router_regs_avmm
    import router_stats_pkg::*;
(
    input  logic                                 avmm_clk_ifc,
    input  logic                                 peripheral_sresetn_core,
    input  avmm_req_t                            avmm_req,
    output avmm_rsp_t                            avmm_rsp,
    input  logic [`ROUTER_NUM_ING_PORTS-1:0]     ing_ports_connected,
    input  logic [`ROUTER_NUM_EGR_PORTS-1:0]     egr_ports_connected,
    output logic [`ROUTER_NUM_ING_PORTS-1:0]     ing_phys_ports_enable,
    output logic [`ROUTER_NUM_EGR_PORTS-1:0]     egr_phys_ports_enable,
    output logic [`ROUTER_NUM_ING_PORTS-1:0]     ing_policer_enable,
    output logic [`ROUTER_NUM_ING_PORTS-1:0]     ing_sample_con,
    output logic [`ROUTER_NUM_EGR_PORTS-1:0]     egr_sample_con,
    output cntr_sel_t                            ing_read_sel,
    output cntr_sel_t                            egr_read_sel,
    input  logic [`ROUTER_AVMM_DATA_WIDTH-1:0]   ing_read_data,
    input  logic [`ROUTER_AVMM_DATA_WIDTH-1:0]   egr_read_data
);

    localparam int NI  = `ROUTER_NUM_ING_PORTS;
    localparam int NE  = `ROUTER_NUM_EGR_PORTS;
    localparam int DW  = `ROUTER_AVMM_DATA_WIDTH;
    localparam int WAW = `ROUTER_AVMM_ADDR_WIDTH - 2;

    // Constant identity and parameter words
    localparam logic [DW-1:0] VERSION_ID_WORD = {
        16'(`ROUTER_MODULE_VERSION), 16'(`ROUTER_MODULE_ID)
    };
    localparam logic [DW-1:0] PARAMS0_WORD = {
        8'd0, 8'(`ROUTER_DATA_BYTES), 8'(NE), 8'(NI)
    };
    localparam logic [DW-1:0] PARAMS1_WORD = {
        16'(`ROUTER_CLK_PERIOD_PS), 16'(`ROUTER_MTU_BYTES)
    };

    logic [WAW-1:0] word_addr;
    logic           addr_ok;
    logic [DW-1:0]  rd_word;
    logic [DW-1:0]  wr_merged;

    function automatic logic [DW-1:0] lane_merge(
        input logic [DW-1:0]   cur,
        input logic [DW-1:0]   wdata,
        input logic [DW/8-1:0] be
    );
        logic [DW-1:0] res;
        res = cur;
        for (int b = 0; b < DW/8; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign word_addr = avmm_req.address[`ROUTER_AVMM_ADDR_WIDTH-1:2];
    assign addr_ok   = word_addr < REG_COUNT;

    ////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd_word = '0;
        case (word_addr)
            VERSION_ID:           rd_word = VERSION_ID_WORD;
            PARAMS0:              rd_word = PARAMS0_WORD;
            PARAMS1:              rd_word = PARAMS1_WORD;
            ING_PORT_ENABLE_CON:  rd_word = DW'(ing_phys_ports_enable);
            EGR_PORT_ENABLE_CON:  rd_word = DW'(egr_phys_ports_enable);
            ING_PORT_ENABLE_STAT: rd_word = DW'(ing_ports_connected);
            EGR_PORT_ENABLE_STAT: rd_word = DW'(egr_ports_connected);
            ING_CNTRS_SAMPLE_CON: rd_word = DW'(ing_sample_con);
            ING_CNTRS_READ_SEL:   rd_word = DW'(ing_read_sel);
            ING_CNTRS_READ_DATA:  rd_word = ing_read_data;
            EGR_CNTRS_SAMPLE_CON: rd_word = DW'(egr_sample_con);
            EGR_CNTRS_READ_SEL:   rd_word = DW'(egr_read_sel);
            EGR_CNTRS_READ_DATA:  rd_word = egr_read_data;
            ING_POLICER_ENABLE:   rd_word = DW'(ing_policer_enable);
            default:              rd_word = '0;
        endcase
    end

    // Current value with the enabled lanes replaced
    assign wr_merged = lane_merge(rd_word, avmm_req.writedata, avmm_req.byteenable);

    ////////////////////////////////////////////////////////////
    // Writable registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            ing_phys_ports_enable <= '1;
            egr_phys_ports_enable <= '1;
            ing_policer_enable    <= '0;
            ing_sample_con        <= '0;
            egr_sample_con        <= '0;
            ing_read_sel          <= '0;
            egr_read_sel          <= '0;
        end else if (avmm_req.write) begin
            // Read-only and unmapped addresses fall through
            case (word_addr)
                ING_PORT_ENABLE_CON:  ing_phys_ports_enable <= wr_merged[NI-1:0];
                EGR_PORT_ENABLE_CON:  egr_phys_ports_enable <= wr_merged[NE-1:0];
                ING_CNTRS_SAMPLE_CON: ing_sample_con        <= wr_merged[NI-1:0];
                ING_CNTRS_READ_SEL:   ing_read_sel          <= cntr_sel_t'(wr_merged[15:0]);
                EGR_CNTRS_SAMPLE_CON: egr_sample_con        <= wr_merged[NE-1:0];
                EGR_CNTRS_READ_SEL:   egr_read_sel          <= cntr_sel_t'(wr_merged[15:0]);
                ING_POLICER_ENABLE:   ing_policer_enable    <= wr_merged[NI-1:0];
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Response
    ////////////////////////////////////////////////////////////

    always_ff @(posedge avmm_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            avmm_rsp.readdatavalid      <= 1'b0;
            avmm_rsp.writeresponsevalid <= 1'b0;
        end else begin
            avmm_rsp.readdatavalid      <= avmm_req.read;
            avmm_rsp.writeresponsevalid <= avmm_req.write;
        end
        // Code and read data are captured with each request
        if (avmm_req.read || avmm_req.write) begin
            avmm_rsp.response <= addr_ok ? RESP_OKAY : RESP_SLAVE_ERROR;
        end
        if (avmm_req.read) begin
            avmm_rsp.readdata <= rd_word;
        end
    end

endmodule

// File: hw/router_stats_top.sv
/* Router statistics top level */

`timescale 1ns/10ps
`include "router_stats_macros.svh"

module router_stats_top
    import router_stats_pkg::*;
(
    input  logic                                    avmm_clk_ifc,
    input  logic                                    peripheral_sresetn_core,
    input  avmm_req_t                               avmm_req,
    output avmm_rsp_t                               avmm_rsp,
    input  prof_cnt_t [`ROUTER_NUM_ING_PORTS-1:0]   ing_prof_cnts,
    input  logic [`ROUTER_NUM_ING_PORTS-1:0]        ing_async_fifo_overflow,
    input  logic [`ROUTER_NUM_ING_PORTS-1:0]        ing_buf_overflow,
    input  logic [`ROUTER_NUM_ING_PORTS-1:0]        ing_ports_connected,
    input  prof_cnt_t [`ROUTER_NUM_EGR_PORTS-1:0]   egr_prof_cnts,
    input  logic [`ROUTER_NUM_EGR_PORTS-1:0]        egr_buf_full_drop,
    input  logic [`ROUTER_NUM_EGR_PORTS-1:0]        egr_ports_connected,
    output logic [`ROUTER_NUM_ING_PORTS-1:0]        ing_phys_ports_enable,
    output logic [`ROUTER_NUM_EGR_PORTS-1:0]        egr_phys_ports_enable,
    output logic [`ROUTER_NUM_ING_PORTS-1:0]        ing_policer_enable
);

    localparam int NI = `ROUTER_NUM_ING_PORTS;
    localparam int NE = `ROUTER_NUM_EGR_PORTS;

    logic [NI-1:0]                     ing_sample_con;
    logic [NE-1:0]                     egr_sample_con;
    cntr_sel_t                         ing_read_sel;
    cntr_sel_t                         egr_read_sel;
    logic [`ROUTER_CNTR_WIDTH-1:0]     ing_read_data;
    logic [`ROUTER_CNTR_WIDTH-1:0]     egr_read_data;
    logic [NI-1:0][1:0]                ing_drop;
    logic [NE-1:0][0:0]                egr_drop;

    // Async FIFO overflow on bit 1 so it snapshots as word 3
    for (genvar p = 0; p < NI; p++) begin : g_ing_drop
        assign ing_drop[p] = {ing_async_fifo_overflow[p], ing_buf_overflow[p]};
    end

    for (genvar p = 0; p < NE; p++) begin : g_egr_drop
        assign egr_drop[p] = egr_buf_full_drop[p];
    end

    router_regs_avmm regs (
        .avmm_clk_ifc            (avmm_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .avmm_req                (avmm_req),
        .avmm_rsp                (avmm_rsp),
        .ing_ports_connected     (ing_ports_connected),
        .egr_ports_connected     (egr_ports_connected),
        .ing_phys_ports_enable   (ing_phys_ports_enable),
        .egr_phys_ports_enable   (egr_phys_ports_enable),
        .ing_policer_enable      (ing_policer_enable),
        .ing_sample_con          (ing_sample_con),
        .egr_sample_con          (egr_sample_con),
        .ing_read_sel            (ing_read_sel),
        .egr_read_sel            (egr_read_sel),
        .ing_read_data           (ing_read_data),
        .egr_read_data           (egr_read_data)
    );

    port_stats_bank #(
        .NUM_PORTS      (NI),
        .NUM_EVENTS     (2),
        .CNTRS_PER_PORT (`ROUTER_ING_CNTRS_PER_PORT),
        .cnt_set_t      (ing_cnt_set_t)
    ) ing_stats (
        .avmm_clk_ifc            (avmm_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .prof_cnts               (ing_prof_cnts),
        .drop_events             (ing_drop),
        .sample_con              (ing_sample_con),
        .read_sel                (ing_read_sel),
        .read_data               (ing_read_data)
    );

    port_stats_bank #(
        .NUM_PORTS      (NE),
        .NUM_EVENTS     (1),
        .CNTRS_PER_PORT (`ROUTER_EGR_CNTRS_PER_PORT),
        .cnt_set_t      (egr_cnt_set_t)
    ) egr_stats (
        .avmm_clk_ifc            (avmm_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .prof_cnts               (egr_prof_cnts),
        .drop_events             (egr_drop),
        .sample_con              (egr_sample_con),
        .read_sel                (egr_read_sel),
        .read_data               (egr_read_data)
    );

endmodule

// File: verif/router_stats_tb.sv
/* Router statistics testbench */

`timescale 1ns/10ps
`include "router_stats_macros.svh"

module router_stats_tb
    import router_stats_pkg::*;
();

    localparam int NI            = `ROUTER_NUM_ING_PORTS;
    localparam int NE            = `ROUTER_NUM_EGR_PORTS;
    localparam int ING_CPP       = `ROUTER_ING_CNTRS_PER_PORT;
    localparam int EGR_CPP       = `ROUTER_EGR_CNTRS_PER_PORT;
    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 10;
    localparam int SETTLE_CYCLES = 4;
    localparam int MAX_PULSES    = (NI > NE + 1) ? NI : NE + 1;

    localparam logic [31:0] ING_MASK    = 32'((1 << NI) - 1);
    localparam logic [31:0] EGR_MASK    = 32'((1 << NE) - 1);
    localparam logic [1:0]  OKAY_CODE   = 2'b00;
    localparam logic [1:0]  SLVERR_CODE = 2'b10;

    // Cycle budget per test, with margin on each bus access
    localparam int BUS_CYCLES   = 3;
    localparam int STAT_CHECK   = 2 * BUS_CYCLES + SETTLE_CYCLES;
    localparam int SAMPLE_STEP  = 2 * BUS_CYCLES + SETTLE_CYCLES;
    localparam int T1_CYCLES    = 14 * BUS_CYCLES;
    localparam int T2_CYCLES    = 8 * 5 * 2 * BUS_CYCLES + 4 * BUS_CYCLES;
    localparam int T3_CYCLES    = 10 * BUS_CYCLES;
    localparam int T4_CYCLES    = 3 * SAMPLE_STEP +
        ((NI + 1) * (ING_CPP + 1) + (NE + 1) * (EGR_CPP + 1) + 2) * STAT_CHECK;
    localparam int T5_CYCLES    = 5 * SAMPLE_STEP + 3 * MAX_PULSES +
        2 * (2 * NI + NE) * STAT_CHECK;
    localparam int WATCHDOG_NS  = 2 * CLK_PERIOD * (RESET_CYCLES + T1_CYCLES +
        T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES);

    logic               avmm_clk_ifc;
    logic               peripheral_sresetn_core;
    avmm_req_t          avmm_req;
    avmm_rsp_t          avmm_rsp;
    prof_cnt_t [NI-1:0] ing_prof_cnts;
    logic [NI-1:0]      ing_async_fifo_overflow;
    logic [NI-1:0]      ing_buf_overflow;
    logic [NI-1:0]      ing_ports_connected;
    prof_cnt_t [NE-1:0] egr_prof_cnts;
    logic [NE-1:0]      egr_buf_full_drop;
    logic [NE-1:0]      egr_ports_connected;
    logic [NI-1:0]      ing_phys_ports_enable;
    logic [NE-1:0]      egr_phys_ports_enable;
    logic [NI-1:0]      ing_policer_enable;

    int          errors;
    logic [31:0] rng_state;

    router_stats_top dut (
        .avmm_clk_ifc            (avmm_clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .avmm_req                (avmm_req),
        .avmm_rsp                (avmm_rsp),
        .ing_prof_cnts           (ing_prof_cnts),
        .ing_async_fifo_overflow (ing_async_fifo_overflow),
        .ing_buf_overflow        (ing_buf_overflow),
        .ing_ports_connected     (ing_ports_connected),
        .egr_prof_cnts           (egr_prof_cnts),
        .egr_buf_full_drop       (egr_buf_full_drop),
        .egr_ports_connected     (egr_ports_connected),
        .ing_phys_ports_enable   (ing_phys_ports_enable),
        .egr_phys_ports_enable   (egr_phys_ports_enable),
        .ing_policer_enable      (ing_policer_enable)
    );

    initial begin : clock_gen
        avmm_clk_ifc = 1'b0;
        forever #(CLK_PERIOD / 2) avmm_clk_ifc = ~avmm_clk_ifc;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    // All tasks start and end 1 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge avmm_clk_ifc);
        #1;
    endtask

    task automatic avmm_write(input reg_addr_e addr, input logic [31:0] data,
                              input logic [3:0] be, input logic [1:0] exp_resp);
        int waited;
        waited = 0;
        avmm_req.address    = {addr, 2'b00};
        avmm_req.writedata  = data;
        avmm_req.byteenable = be;
        avmm_req.write      = 1'b1;
        wait_cycles(1);
        avmm_req.write = 1'b0;
        while (!avmm_rsp.writeresponsevalid && waited < BUS_CYCLES) begin
            wait_cycles(1);
            waited++;
        end
        if (!avmm_rsp.writeresponsevalid) begin
            note_failure($sformatf("No write response for word address %0d", addr));
        end else begin
            check_value("avmm_rsp.response", 32'(avmm_rsp.response), 32'(exp_resp));
        end
    endtask

    task automatic avmm_read_check(input reg_addr_e addr, input logic [31:0] exp_data,
                                   input logic [1:0] exp_resp, input string label);
        int waited;
        waited = 0;
        avmm_req.address = {addr, 2'b00};
        avmm_req.read    = 1'b1;
        wait_cycles(1);
        avmm_req.read = 1'b0;
        while (!avmm_rsp.readdatavalid && waited < BUS_CYCLES) begin
            wait_cycles(1);
            waited++;
        end
        if (!avmm_rsp.readdatavalid) begin
            note_failure($sformatf("No read data for word address %0d", addr));
        end else begin
            check_value($sformatf("avmm_rsp.readdata (%s)", label),
                        avmm_rsp.readdata, exp_data);
            check_value("avmm_rsp.response", 32'(avmm_rsp.response), 32'(exp_resp));
        end
    endtask

    task automatic write_sample_con(input logic [31:0] ing_val, input logic [31:0] egr_val);
        avmm_write(ING_CNTRS_SAMPLE_CON, ing_val, 4'hF, OKAY_CODE);
        avmm_write(EGR_CNTRS_SAMPLE_CON, egr_val, 4'hF, OKAY_CODE);
        wait_cycles(SETTLE_CYCLES);
    endtask

    task automatic stat_read_check(input bit egress, input logic [7:0] port,
                                   input logic [7:0] cntr, input logic [31:0] exp);
        string label;
        label = $sformatf("%s port %0d word %0d", egress ? "egr" : "ing", port, cntr);
        if (egress) begin
            avmm_write(EGR_CNTRS_READ_SEL, {16'h0, port, cntr}, 4'hF, OKAY_CODE);
            wait_cycles(SETTLE_CYCLES);
            avmm_read_check(EGR_CNTRS_READ_DATA, exp, OKAY_CODE, label);
        end else begin
            avmm_write(ING_CNTRS_READ_SEL, {16'h0, port, cntr}, 4'hF, OKAY_CODE);
            wait_cycles(SETTLE_CYCLES);
            avmm_read_check(ING_CNTRS_READ_DATA, exp, OKAY_CODE, label);
        end
    endtask

    task automatic set_profiles(input logic [31:0] value);
        for (int p = 0; p < NI; p++) begin
            ing_prof_cnts[p] = {value, value, value};
        end
        for (int p = 0; p < NE; p++) begin
            egr_prof_cnts[p] = {value, value, value};
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_values();
        avmm_read_check(VERSION_ID, (32'(`ROUTER_MODULE_VERSION) << 16) |
                        32'(`ROUTER_MODULE_ID), OKAY_CODE, "VERSION_ID");
        avmm_read_check(PARAMS0, (32'(`ROUTER_DATA_BYTES) << 16) | (32'(NE) << 8) |
                        32'(NI), OKAY_CODE, "PARAMS0");
        avmm_read_check(PARAMS1, (32'(`ROUTER_CLK_PERIOD_PS) << 16) |
                        32'(`ROUTER_MTU_BYTES), OKAY_CODE, "PARAMS1");
        avmm_read_check(ING_PORT_ENABLE_CON, ING_MASK, OKAY_CODE, "ING_PORT_ENABLE_CON");
        avmm_read_check(EGR_PORT_ENABLE_CON, EGR_MASK, OKAY_CODE, "EGR_PORT_ENABLE_CON");
        avmm_read_check(ING_PORT_ENABLE_STAT, 32'(ing_ports_connected), OKAY_CODE,
                        "ING_PORT_ENABLE_STAT");
        avmm_read_check(EGR_PORT_ENABLE_STAT, 32'(egr_ports_connected), OKAY_CODE,
                        "EGR_PORT_ENABLE_STAT");
        avmm_read_check(ING_CNTRS_SAMPLE_CON, 32'h0, OKAY_CODE, "ING_CNTRS_SAMPLE_CON");
        avmm_read_check(ING_CNTRS_READ_SEL, 32'h0, OKAY_CODE, "ING_CNTRS_READ_SEL");
        avmm_read_check(ING_CNTRS_READ_DATA, 32'h0, OKAY_CODE, "ING_CNTRS_READ_DATA");
        avmm_read_check(EGR_CNTRS_SAMPLE_CON, 32'h0, OKAY_CODE, "EGR_CNTRS_SAMPLE_CON");
        avmm_read_check(EGR_CNTRS_READ_SEL, 32'h0, OKAY_CODE, "EGR_CNTRS_READ_SEL");
        avmm_read_check(EGR_CNTRS_READ_DATA, 32'h0, OKAY_CODE, "EGR_CNTRS_READ_DATA");
        avmm_read_check(ING_POLICER_ENABLE, 32'h0, OKAY_CODE, "ING_POLICER_ENABLE");
    endtask

    task automatic test_control_regs();
        reg_addr_e   regs   [5] = '{ING_PORT_ENABLE_CON, EGR_PORT_ENABLE_CON,
                                    ING_POLICER_ENABLE, ING_CNTRS_READ_SEL,
                                    EGR_CNTRS_READ_SEL};
        logic [31:0] masks  [5] = '{ING_MASK, EGR_MASK, ING_MASK, 32'hFFFF, 32'hFFFF};
        logic [31:0] shadow [5] = '{ING_MASK, EGR_MASK, 32'h0, 32'h0, 32'h0};
        logic [31:0] wdata;
        logic [31:0] be_rand;
        logic [31:0] m;
        for (int round = 0; round < 8; round++) begin
            for (int r = 0; r < 5; r++) begin
                wdata     = next_random();
                be_rand   = next_random();
                m         = lane_mask(be_rand[3:0]);
                shadow[r] = ((shadow[r] & ~m) | (wdata & m)) & masks[r];
                avmm_write(regs[r], wdata, be_rand[3:0], OKAY_CODE);
                avmm_read_check(regs[r], shadow[r], OKAY_CODE, regs[r].name());
            end
            check_value("ing_phys_ports_enable", 32'(ing_phys_ports_enable), shadow[0]);
            check_value("egr_phys_ports_enable", 32'(egr_phys_ports_enable), shadow[1]);
            check_value("ing_policer_enable", 32'(ing_policer_enable), shadow[2]);
        end
        // Connected vectors come straight from the inputs
        wdata = next_random();
        ing_ports_connected = wdata[NI-1:0];
        egr_ports_connected = wdata[NE+15:16];
        avmm_read_check(ING_PORT_ENABLE_STAT, wdata & ING_MASK, OKAY_CODE,
                        "ING_PORT_ENABLE_STAT");
        avmm_read_check(EGR_PORT_ENABLE_STAT, (wdata >> 16) & EGR_MASK, OKAY_CODE,
                        "EGR_PORT_ENABLE_STAT");
    endtask

    task automatic test_bad_addresses();
        reg_addr_e addr;
        for (int k = 0; k < 4; k++) begin
            addr = reg_addr_e'(int'(REG_COUNT) + k);
            avmm_read_check(addr, 32'h0, SLVERR_CODE, "unmapped address");
            avmm_write(addr, next_random(), 4'hF, SLVERR_CODE);
        end
        avmm_write(PARAMS0, 32'hFFFF_FFFF, 4'hF, OKAY_CODE);
        avmm_read_check(PARAMS0, (32'(`ROUTER_DATA_BYTES) << 16) | (32'(NE) << 8) |
                        32'(NI), OKAY_CODE, "PARAMS0 after write");
    endtask

    task automatic test_profile_snapshot();
        logic [31:0] mask_ing;
        logic [31:0] mask_egr;
        logic [31:0] exp;
        set_profiles(32'h0);
        write_sample_con(ING_MASK, EGR_MASK);
        set_profiles(32'hAAAA_AAAA);
        write_sample_con(32'h0, 32'h0);
        mask_ing = next_random() & ING_MASK;
        mask_egr = next_random() & EGR_MASK;
        write_sample_con(mask_ing, mask_egr);
        // One port and one word past the end on each side
        for (int p = 0; p <= NI; p++) begin
            for (int c = 0; c <= ING_CPP; c++) begin
                exp = (p < NI && c < 3 && mask_ing[p]) ? 32'hAAAA_AAAA : 32'h0;
                stat_read_check(1'b0, 8'(p), 8'(c), exp);
            end
        end
        for (int p = 0; p <= NE; p++) begin
            for (int c = 0; c <= EGR_CPP; c++) begin
                exp = (p < NE && c < 3 && mask_egr[p]) ? 32'hAAAA_AAAA : 32'h0;
                stat_read_check(1'b1, 8'(p), 8'(c), exp);
            end
        end
        stat_read_check(1'b0, 8'hFF, 8'h0, 32'h0);
        stat_read_check(1'b1, 8'h0, 8'hFF, 32'h0);
    endtask

    task automatic test_drop_counting();
        write_sample_con(32'h0, 32'h0);
        // Port p sees p+1 ingress pulses per event and p+2 egress pulses
        // Each pulse stays high for two cycles
        for (int k = 0; k < MAX_PULSES; k++) begin
            for (int p = 0; p < NI; p++) begin
                ing_async_fifo_overflow[p] = (k < p + 1);
                ing_buf_overflow[p]        = (k < p + 1);
            end
            for (int p = 0; p < NE; p++) begin
                egr_buf_full_drop[p] = (k < p + 2);
            end
            wait_cycles(2);
            ing_async_fifo_overflow = '0;
            ing_buf_overflow        = '0;
            egr_buf_full_drop       = '0;
            wait_cycles(1);
        end
        write_sample_con(ING_MASK, EGR_MASK);
        for (int p = 0; p < NI; p++) begin
            stat_read_check(1'b0, 8'(p), 8'd3, 32'(p + 1));
            stat_read_check(1'b0, 8'(p), 8'd4, 32'(p + 1));
        end
        for (int p = 0; p < NE; p++) begin
            stat_read_check(1'b1, 8'(p), 8'd3, 32'(p + 2));
        end
        // Counts were cleared by the sample above
        write_sample_con(32'h0, 32'h0);
        write_sample_con(ING_MASK, EGR_MASK);
        for (int p = 0; p < NI; p++) begin
            stat_read_check(1'b0, 8'(p), 8'd3, 32'h0);
            stat_read_check(1'b0, 8'(p), 8'd4, 32'h0);
        end
        for (int p = 0; p < NE; p++) begin
            stat_read_check(1'b1, 8'(p), 8'd3, 32'h0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin : main
        errors                  = 0;
        rng_state               = 32'd18504;
        peripheral_sresetn_core = 1'b0;
        avmm_req                = '0;
        ing_prof_cnts           = '0;
        egr_prof_cnts           = '0;
        ing_async_fifo_overflow = '0;
        ing_buf_overflow        = '0;
        egr_buf_full_drop       = '0;
        ing_ports_connected     = 11'h5A5;
        egr_ports_connected     = 11'h3C3;
        repeat (RESET_CYCLES) @(posedge avmm_clk_ifc);
        #1;
        peripheral_sresetn_core = 1'b1;
        wait_cycles(1);

        test_reset_values();
        test_control_regs();
        test_bad_addresses();
        test_profile_snapshot();
        test_drop_counting();

        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hw
hw/router_stats_pkg.sv
hw/port_stats_bank.sv
hw/router_regs_avmm.sv
hw/router_stats_top.sv
verif/router_stats_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the router statistics testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    -f filelist.f \
    --top-module router_stats_tb \
    -o router_stats_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/router_stats_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
